// ==== build.f ====
hw/fabric_pkg.sv
hw/credit_fifo.sv
hw/req_router.sv
hw/mem_target.sv
hw/rsp_merger.sv
hw/mem_fabric_top.sv
dv/mem_fabric_properties.sv
dv/tb_clock_gen.sv
dv/tb_mem_fabric.sv

// ==== Bender.yml ====
package:
  name: mem_fabric

sources:
  - files:
      - hw/fabric_pkg.sv
      - hw/credit_fifo.sv
      - hw/req_router.sv
      - hw/mem_target.sv
      - hw/rsp_merger.sv
      - hw/mem_fabric_top.sv
  - target: simulation
    files:
      - dv/mem_fabric_properties.sv
      - dv/tb_clock_gen.sv
      - dv/tb_mem_fabric.sv

// ==== dv/tb_mem_fabric.sv ====
// Table only reads words it wrote first; RAM contents start undefined and are never compared
`timescale 1ns/10ps
`default_nettype none

module tb_mem_fabric;

    localparam int unsigned CREDITS          = 4;
    localparam int unsigned TARGET_WORDS     = 256;
    localparam int unsigned NM               = fabric_pkg::NUM_MASTERS;
    localparam int unsigned NT               = fabric_pkg::NUM_TARGETS;
    localparam int unsigned NTAGS            = 2 ** fabric_pkg::TAG_W;
    localparam int unsigned CYCLES_PER_ENTRY = 200;

    typedef logic [fabric_pkg::ADDR_W-1:0] addr_t;
    typedef logic [fabric_pkg::DATA_W-1:0] data_t;

    typedef struct packed {
        logic [fabric_pkg::SRC_W-1:0] mst;
        logic                         we;
        addr_t                        addr;
        logic [fabric_pkg::BE_W-1:0]  be;
        data_t                        wdata;
        logic [fabric_pkg::TAG_W-1:0] tag;
    } entry_t;

    logic                         clk;
    logic                         rst_n;
    logic [NM-1:0]                mst_req_valid;
    fabric_pkg::req_t             mst_req [NM];
    logic [NM-1:0]                mst_req_ready;
    logic [NM-1:0]                mst_rsp_valid;
    fabric_pkg::rsp_t             mst_rsp [NM];
    logic [NM-1:0]                mst_rsp_ready;

    entry_t                       table_q [$];
    int                           phase_end [$];
    logic [fabric_pkg::TAG_W-1:0] tag_next [NM];
    data_t                        ref_mem [bit [fabric_pkg::ADDR_W-1:0]];
    int                           pend_wr [bit [fabric_pkg::ADDR_W-1:0]];
    logic                         out_v [NM][NTAGS];
    logic                         out_we [NM][NTAGS];
    addr_t                        out_word [NM][NTAGS];
    fabric_pkg::rsp_t             out_exp [NM][NTAGS];
    int                           out_cnt [NM];
    logic [31:0]                  rng;
    int                           ready_mode;
    int                           stall_cyc;
    int                           stall_progress;
    logic                         table_ready;

    tb_clock_gen #(
        .PERIOD_NS    ( 10.0 ),
        .RESET_CYCLES ( 4    )
    ) i_clock_gen (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    mem_fabric_top #(
        .CREDITS      ( CREDITS      ),
        .TARGET_WORDS ( TARGET_WORDS )
    ) uut (
        .clk_i           ( clk           ),
        .rst_n_i         ( rst_n         ),
        .mst_req_valid_i ( mst_req_valid ),
        .mst_req_i       ( mst_req       ),
        .mst_req_ready_o ( mst_req_ready ),
        .mst_rsp_valid_o ( mst_rsp_valid ),
        .mst_rsp_o       ( mst_rsp       ),
        .mst_rsp_ready_i ( mst_rsp_ready )
    );

    // ----------------------------------------------------------------------
    // Helpers and checks
    // ----------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic decode_hit(input addr_t addr);
        addr_t region;
        addr_t offset;
        region = addr >> fabric_pkg::REGION_SHIFT;
        offset = addr & ((addr_t'(1) << fabric_pkg::REGION_SHIFT) - 1);
        return (region < NT) && (offset < TARGET_WORDS * 4);
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got));
        end
    endtask

    task automatic check_rsp(input string name, input fabric_pkg::rsp_t exp,
                             input fabric_pkg::rsp_t got);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got));
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus table
    // ----------------------------------------------------------------------
    task automatic add_entry(input int m, input logic we, input addr_t addr,
                             input logic [3:0] be, input data_t wdata);
        entry_t e;
        e.mst   = fabric_pkg::SRC_W'(m);
        e.we    = we;
        e.addr  = addr;
        e.be    = be;
        e.wdata = wdata;
        e.tag   = tag_next[m];
        tag_next[m] = tag_next[m] + 1'b1;
        table_q.push_back(e);
    endtask

    // Region 3 in the top bits gives decode errors
    task automatic add_random(input int m);
        logic [31:0] r;
        addr_t       addr;
        rng  = xorshift32(rng);
        r    = rng;
        rng  = xorshift32(rng);
        addr = (addr_t'(r[1:0]) << fabric_pkg::REGION_SHIFT) | addr_t'({r[4:2], r[9:8]});
        add_entry(m, r[10], addr, r[14:11], rng);
    endtask

    task automatic build_table();
        addr_t base;
        addr_t last;
        last = addr_t'(TARGET_WORDS * 4 - 4);
        for (int k = 0; k < NT; k++) begin
            base = addr_t'(k) << fabric_pkg::REGION_SHIFT;
            for (int w = 0; w < 8; w++) begin
                rng = xorshift32(rng);
                add_entry(w % 2, 1'b1, base + addr_t'(4 * w), 4'hf, rng);
            end
            add_entry(0, 1'b1, base + 32'h10, 4'hf, 32'hcafe_0000 + k);
            add_entry(0, 1'b1, base + 32'h10, 4'b0101, 32'h1122_3344);
            add_entry(0, 1'b0, base + 32'h10, 4'hf, '0);
            add_entry(0, 1'b0, base + 32'h12, 4'hf, '0);
            add_entry(1, 1'b1, base + last, 4'hf, 32'h0bad_f00d ^ k);
            add_entry(1, 1'b1, base + last, 4'b1010, 32'h5566_7788);
            add_entry(1, 1'b0, base + last, 4'hf, '0);
        end
        phase_end.push_back(table_q.size());
        for (int k = 0; k < NT; k++) begin
            base = addr_t'(k) << fabric_pkg::REGION_SHIFT;
            add_entry(k % 2, 1'b0, base + addr_t'(TARGET_WORDS * 4), 4'hf, '0);
            add_entry((k + 1) % 2, 1'b1, base + 32'h0fff_fffc, 4'hf, 32'hdead_beef);
        end
        add_entry(0, 1'b0, 32'h3000_0000, 4'hf, '0);
        add_entry(1, 1'b1, 32'h4000_0008, 4'h3, 32'h1234_5678);
        add_entry(0, 1'b1, 32'hffff_fffc, 4'hf, 32'h0);
        add_entry(1, 1'b0, 32'h2000_0010, 4'hf, '0);
        phase_end.push_back(table_q.size());
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < 20; i++) begin
                add_random(0);
                add_random(1);
            end
            phase_end.push_back(table_q.size());
        end
    endtask

    // ----------------------------------------------------------------------
    // Request driver, entered just after a falling edge
    // ----------------------------------------------------------------------
    task automatic issue(input entry_t e);
        int               m;
        int               t;
        addr_t            word;
        data_t            merged;
        fabric_pkg::rsp_t exp;
        m    = int'(e.mst);
        t    = int'(e.tag);
        word = {e.addr[fabric_pkg::ADDR_W-1:2], 2'b00};
        // Tag must be free, and a read waits for older writes to its word
        while (out_v[m][t] || (!e.we && pend_wr.exists(word) && pend_wr[word] > 0)) begin
            @(negedge clk);
        end
        mst_req[m]       = '0;
        mst_req[m].we    = e.we;
        mst_req[m].addr  = e.addr;
        mst_req[m].be    = e.be;
        mst_req[m].wdata = e.wdata;
        mst_req[m].tag   = e.tag;
        mst_req_valid[m] = 1'b1;
        do begin
            @(posedge clk);
        end while (!mst_req_ready[m]);
        exp     = '0;
        exp.tag = e.tag;
        exp.src = e.mst;
        if (!decode_hit(e.addr)) begin
            exp.err = 1'b1;
        end else if (e.we) begin
            merged = ref_mem.exists(word) ? ref_mem[word] : 'x;
            for (int b = 0; b < fabric_pkg::BE_W; b++) begin
                if (e.be[b]) begin
                    merged[8*b +: 8] = e.wdata[8*b +: 8];
                end
            end
            ref_mem[word] = merged;
        end else begin
            exp.rdata = ref_mem.exists(word) ? ref_mem[word] : 'x;
        end
        if (e.we) begin
            pend_wr[word] = (pend_wr.exists(word) ? pend_wr[word] : 0) + 1;
        end
        out_v[m][t]    = 1'b1;
        out_we[m][t]   = e.we;
        out_word[m][t] = word;
        out_exp[m][t]  = exp;
        out_cnt[m]++;
        @(negedge clk);
        mst_req_valid[m] = 1'b0;
    endtask

    task automatic drive_master(input int m, input int lo, input int hi);
        @(negedge clk);
        for (int i = lo; i < hi; i++) begin
            if (int'(table_q[i].mst) == m) begin
                issue(table_q[i]);
            end
        end
    endtask

    task automatic run_phase(input int lo, input int hi, input int mode);
        ready_mode = mode;
        fork
            drive_master(0, lo, hi);
            drive_master(1, lo, hi);
        join
        while (out_cnt[0] != 0 || out_cnt[1] != 0) begin
            @(negedge clk);
        end
    endtask

    // ----------------------------------------------------------------------
    // Response side
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        int t;
        if (rst_n) begin
            for (int m = 0; m < NM; m++) begin
                if (mst_rsp_valid[m] && mst_rsp_ready[m]) begin
                    t = int'(mst_rsp[m].tag);
                    if (!out_v[m][t]) begin
                        fail_now($sformatf("Master %0d got a response for tag %0d, not outstanding",
                                           m, t));
                    end
                    check_rsp($sformatf("mst_rsp_o[%0d]", m), out_exp[m][t], mst_rsp[m]);
                    out_v[m][t] = 1'b0;
                    out_cnt[m]--;
                    if (out_we[m][t]) begin
                        pend_wr[out_word[m][t]]--;
                    end
                    if (m == 0 && ready_mode == 2 && !mst_rsp_ready[1]) begin
                        stall_progress++;
                    end
                end
            end
        end
    end

    // Mode 0 always ready, 1 random, 2 master 1 held low in long stretches
    initial begin
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            rng = xorshift32(rng);
            stall_cyc++;
            case (ready_mode)
                0: mst_rsp_ready = '1;
                1: mst_rsp_ready = rng[5:4];
                default: begin
                    mst_rsp_ready[0] = 1'b1;
                    mst_rsp_ready[1] = (stall_cyc % 64 >= 48) && rng[3];
                end
            endcase
        end
    end

    initial begin
        wait (table_ready);
        repeat (table_q.size() * CYCLES_PER_ENTRY) @(posedge clk);
        fail_now("Timeout: the table did not complete in the allowed number of cycles");
    end

    initial begin
        mst_req_valid = '0;
        mst_rsp_ready = '1;
        for (int m = 0; m < NM; m++) begin
            mst_req[m]  = '0;
            tag_next[m] = '0;
            out_cnt[m]  = 0;
            for (int t = 0; t < NTAGS; t++) begin
                out_v[m][t] = 1'b0;
            end
        end
        rng            = 32'h55e3;
        ready_mode     = 0;
        stall_cyc      = 0;
        stall_progress = 0;
        table_ready    = 1'b0;
        build_table();
        table_ready = 1'b1;
        @(posedge rst_n);
        // Idle fabric returns nothing
        repeat (20) begin
            @(posedge clk);
            for (int m = 0; m < NM; m++) begin
                check_bit($sformatf("mst_rsp_valid_o[%0d]", m), 1'b0, mst_rsp_valid[m]);
                check_bit($sformatf("mst_req_ready_o[%0d]", m), 1'b0, mst_req_ready[m]);
            end
        end
        run_phase(0, phase_end[0], 0);
        run_phase(phase_end[0], phase_end[1], 1);
        run_phase(phase_end[1], phase_end[2], 1);
        run_phase(phase_end[2], phase_end[3], 2);
        if (stall_progress == 0) begin
            fail_now("Master 0 received no response while master 1 was stalled");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
// Free-running clock from time zero; reset is released on a falling edge after RESET_CYCLES
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter real         PERIOD_NS    = 10.0,
    parameter int unsigned RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0);
            clk_o = ~clk_o;
        end
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== dv/mem_fabric_properties.sv ====
// Bound into req_router and reads its credit counters, so port hookup follows that module's names
`timescale 1ns/10ps
`default_nettype none

module mem_fabric_properties #(
    parameter int unsigned CREDITS = 4,
    parameter int unsigned CNT_W   = $clog2(CREDITS + 1)
) (
    input logic                               clk_i,
    input logic                               rst_n_i,
    input logic [fabric_pkg::NUM_TARGETS-1:0] tgt_push_i,
    input logic [CNT_W-1:0]                   cnt_i [fabric_pkg::NUM_TARGETS],
    input logic                               err_rsp_valid_i,
    input fabric_pkg::rsp_t                   err_rsp_i,
    input logic                               err_rsp_ready_i
);

    for (genvar k = 0; k < fabric_pkg::NUM_TARGETS; k++) begin : g_region
        a_push_needs_credit: assert property (
            @(posedge clk_i) disable iff (!rst_n_i) tgt_push_i[k] |-> (cnt_i[k] != '0)
        ) else $error("Region %0d pushed with its credit count at zero", k);

        a_credit_bound: assert property (
            @(posedge clk_i) disable iff (!rst_n_i) cnt_i[k] <= CREDITS
        ) else $error("Region %0d credit count above %0d", k, CREDITS);
    end

    // Stalled error response must hold
    a_err_rsp_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        err_rsp_valid_i && !err_rsp_ready_i |=> $stable(err_rsp_i)
    ) else $error("Error response changed while stalled");

endmodule

bind req_router mem_fabric_properties #(
    .CREDITS ( CREDITS )
) i_router_props (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .tgt_push_i      ( tgt_push_o      ),
    .cnt_i           ( cnt_q           ),
    .err_rsp_valid_i ( err_rsp_valid_o ),
    .err_rsp_i       ( err_rsp_o       ),
    .err_rsp_ready_i ( err_rsp_ready_i )
);

`default_nettype wire

// ==== hw/mem_fabric_top.sv ====
// Request src fields are overwritten by the router; responses may return out of order across regions
`timescale 1ns/10ps
`default_nettype none

module mem_fabric_top #(
    parameter int unsigned CREDITS      = 4,
    parameter int unsigned TARGET_WORDS = 256
) (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic [fabric_pkg::NUM_MASTERS-1:0] mst_req_valid_i,
    input  fabric_pkg::req_t                   mst_req_i [fabric_pkg::NUM_MASTERS],
    output logic [fabric_pkg::NUM_MASTERS-1:0] mst_req_ready_o,
    output logic [fabric_pkg::NUM_MASTERS-1:0] mst_rsp_valid_o,
    output fabric_pkg::rsp_t                   mst_rsp_o [fabric_pkg::NUM_MASTERS],
    input  logic [fabric_pkg::NUM_MASTERS-1:0] mst_rsp_ready_i
);

    localparam int unsigned NT = fabric_pkg::NUM_TARGETS;

    logic [NT-1:0]    tgt_push;
    fabric_pkg::req_t tgt_req [NT];
    logic [NT-1:0]    tgt_credit;

    // Region responses, with the error queue in the last slot
    logic [NT:0]      rsp_valid;
    fabric_pkg::rsp_t rsp [NT+1];
    logic [NT:0]      rsp_ready;

    req_router #(
        .CREDITS      ( CREDITS      ),
        .TARGET_WORDS ( TARGET_WORDS )
    ) i_req_router (
        .clk_i           ( clk_i         ),
        .rst_n_i         ( rst_n_i       ),
        .mst_req_valid_i ( mst_req_valid_i ),
        .mst_req_i       ( mst_req_i     ),
        .mst_req_ready_o ( mst_req_ready_o ),
        .tgt_push_o      ( tgt_push      ),
        .tgt_req_o       ( tgt_req       ),
        .tgt_credit_i    ( tgt_credit    ),
        .err_rsp_valid_o ( rsp_valid[NT] ),
        .err_rsp_o       ( rsp[NT]       ),
        .err_rsp_ready_i ( rsp_ready[NT] )
    );

    for (genvar k = 0; k < NT; k++) begin : g_region
        mem_target #(
            .CREDITS      ( CREDITS      ),
            .TARGET_WORDS ( TARGET_WORDS )
        ) i_mem_target (
            .clk_i       ( clk_i         ),
            .rst_n_i     ( rst_n_i       ),
            .push_i      ( tgt_push[k]   ),
            .req_i       ( tgt_req[k]    ),
            .credit_o    ( tgt_credit[k] ),
            .rsp_valid_o ( rsp_valid[k]  ),
            .rsp_o       ( rsp[k]        ),
            .rsp_ready_i ( rsp_ready[k]  )
        );
    end

    rsp_merger i_rsp_merger (
        .rsp_valid_i     ( rsp_valid       ),
        .rsp_i           ( rsp             ),
        .rsp_ready_o     ( rsp_ready       ),
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .mst_rsp_valid_o ( mst_rsp_valid_o ),
        .mst_rsp_o       ( mst_rsp_o       ),
        .mst_rsp_ready_i ( mst_rsp_ready_i )
    );

endmodule

`default_nettype wire

// ==== hw/rsp_merger.sv ====
// Responses to one master leave in source round-robin order, not request order; match them by tag
`timescale 1ns/10ps
`default_nettype none

module rsp_merger (
    input  logic [fabric_pkg::NUM_TARGETS:0]   rsp_valid_i,
    input  fabric_pkg::rsp_t                   rsp_i [fabric_pkg::NUM_TARGETS+1],
    output logic [fabric_pkg::NUM_TARGETS:0]   rsp_ready_o,
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    output logic [fabric_pkg::NUM_MASTERS-1:0] mst_rsp_valid_o,
    output fabric_pkg::rsp_t                   mst_rsp_o [fabric_pkg::NUM_MASTERS],
    input  logic [fabric_pkg::NUM_MASTERS-1:0] mst_rsp_ready_i
);

    localparam int unsigned NUM_SRC = fabric_pkg::NUM_TARGETS + 1;
    localparam int unsigned SEL_W   = $clog2(NUM_SRC);
    localparam int unsigned NM      = fabric_pkg::NUM_MASTERS;

    logic [SEL_W-1:0] rr_q [NM];
    logic [SEL_W-1:0] sel  [NM];
    logic [NM-1:0]    sel_v;

    // Per master, first source from its pointer carrying its src
    always_comb begin
        int s;
        rsp_ready_o = '0;
        for (int m = 0; m < NM; m++) begin
            sel_v[m] = 1'b0;
            sel[m]   = rr_q[m];
            for (int i = 0; i < NUM_SRC; i++) begin
                s = (int'(rr_q[m]) + i) % NUM_SRC;
                if (!sel_v[m] && rsp_valid_i[s] && (int'(rsp_i[s].src) == m)) begin
                    sel_v[m] = 1'b1;
                    sel[m]   = SEL_W'(s);
                end
            end
            mst_rsp_valid_o[m] = sel_v[m];
            mst_rsp_o[m]       = rsp_i[sel[m]];
            if (sel_v[m] && mst_rsp_ready_i[m]) begin
                rsp_ready_o[sel[m]] = 1'b1;
            end
        end
    end

    // A stalled winner keeps top priority, so the output holds until taken
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int m = 0; m < NM; m++) begin
                rr_q[m] <= '0;
            end
        end else begin
            for (int m = 0; m < NM; m++) begin
                if (sel_v[m] && mst_rsp_ready_i[m]) begin
                    rr_q[m] <= (int'(sel[m]) == NUM_SRC - 1) ? '0 : sel[m] + 1'b1;
                end else if (sel_v[m]) begin
                    rr_q[m] <= sel[m];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_target.sv ====
// Router only forwards in-range addresses; the word index is taken from the low address bits
`timescale 1ns/10ps
`default_nettype none

module mem_target #(
    parameter int unsigned CREDITS      = 4,
    parameter int unsigned TARGET_WORDS = 256
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             push_i,
    input  fabric_pkg::req_t req_i,
    output logic             credit_o,
    output logic             rsp_valid_o,
    output fabric_pkg::rsp_t rsp_o,
    input  logic             rsp_ready_i
);

    localparam int unsigned WORD_AW = (TARGET_WORDS > 1) ? $clog2(TARGET_WORDS) : 1;

    logic [fabric_pkg::DATA_W-1:0] mem_q [TARGET_WORDS];
    fabric_pkg::req_t              head;
    logic                          q_empty;
    logic                          pop;
    logic [WORD_AW-1:0]            word;
    logic                          rsp_valid_q;
    fabric_pkg::rsp_t              rsp_q;

    credit_fifo #(
        .DEPTH     ( CREDITS           ),
        .payload_t ( fabric_pkg::req_t )
    ) i_req_fifo (
        .clk_i    ( clk_i    ),
        .rst_n_i  ( rst_n_i  ),
        .push_i   ( push_i   ),
        .data_i   ( req_i    ),
        .pop_i    ( pop      ),
        .data_o   ( head     ),
        .empty_o  ( q_empty  ),
        .credit_o ( credit_o )
    );

    // Pop only when the response slot frees up this cycle
    assign pop  = !q_empty && (!rsp_valid_q || rsp_ready_i);
    assign word = head.addr[fabric_pkg::WORD_LSB +: WORD_AW];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (pop) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // Word array and response payload
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (pop) begin
            if (head.we) begin
                for (int b = 0; b < fabric_pkg::BE_W; b++) begin
                    if (head.be[b]) begin
                        mem_q[word][8*b +: 8] <= head.wdata[8*b +: 8];
                    end
                end
            end
            rsp_q.rdata <= head.we ? '0 : mem_q[word];
            rsp_q.err   <= 1'b0;
            rsp_q.tag   <= head.tag;
            rsp_q.src   <= head.src;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// ==== hw/req_router.sv ====
// One request accepted per cycle; a push in flight counts against the credit it will consume
`timescale 1ns/10ps
`default_nettype none

module req_router #(
    parameter int unsigned CREDITS      = 4,
    parameter int unsigned TARGET_WORDS = 256
) (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic [fabric_pkg::NUM_MASTERS-1:0]   mst_req_valid_i,
    input  fabric_pkg::req_t                     mst_req_i [fabric_pkg::NUM_MASTERS],
    output logic [fabric_pkg::NUM_MASTERS-1:0]   mst_req_ready_o,
    output logic [fabric_pkg::NUM_TARGETS-1:0]   tgt_push_o,
    output fabric_pkg::req_t                     tgt_req_o [fabric_pkg::NUM_TARGETS],
    input  logic [fabric_pkg::NUM_TARGETS-1:0]   tgt_credit_i,
    output logic                                 err_rsp_valid_o,
    output fabric_pkg::rsp_t                     err_rsp_o,
    input  logic                                 err_rsp_ready_i
);

    localparam int unsigned CNT_W     = $clog2(CREDITS + 1);
    localparam int unsigned ERR_DEPTH = 2;
    localparam int unsigned ERR_CW    = $clog2(ERR_DEPTH + 1);
    localparam int unsigned NM        = fabric_pkg::NUM_MASTERS;
    localparam int unsigned NT        = fabric_pkg::NUM_TARGETS;

    logic [NM-1:0]                    hit;
    logic [NM-1:0]                    room;
    logic [fabric_pkg::IDX_W-1:0]     idx [NM];
    logic [fabric_pkg::SRC_W-1:0]     rr_q;
    logic [fabric_pkg::SRC_W-1:0]     sel;
    logic                             grant_v;
    logic [CNT_W-1:0]                 cnt_q [NT];
    logic [ERR_CW-1:0]                err_free_q;
    logic [NT-1:0]                    tgt_push_q;
    logic                             err_push_q;
    fabric_pkg::req_t                 req_q;
    fabric_pkg::rsp_t                 err_rsp_d;
    logic                             err_pop;
    logic                             err_empty;

    // ----------------------------------------------------------------------
    // Decode and room check per master
    // ----------------------------------------------------------------------
    always_comb begin
        for (int m = 0; m < NM; m++) begin
            idx[m]  = fabric_pkg::region_idx(mst_req_i[m].addr);
            hit[m]  = fabric_pkg::addr_hit(mst_req_i[m].addr, TARGET_WORDS);
            room[m] = 1'b0;
            if (!hit[m]) begin
                room[m] = err_free_q > ERR_CW'(err_push_q);
            end else begin
                for (int k = 0; k < NT; k++) begin
                    if (idx[m] == fabric_pkg::IDX_W'(k)) begin
                        room[m] = cnt_q[k] > CNT_W'(tgt_push_q[k]);
                    end
                end
            end
        end
    end

    // Round-robin pick among masters with room
    always_comb begin
        int m;
        grant_v = 1'b0;
        sel     = rr_q;
        for (int i = 0; i < NM; i++) begin
            m = (int'(rr_q) + i) % NM;
            if (!grant_v && mst_req_valid_i[m] && room[m]) begin
                grant_v = 1'b1;
                sel     = fabric_pkg::SRC_W'(m);
            end
        end
        for (int j = 0; j < NM; j++) begin
            mst_req_ready_o[j] = grant_v && (int'(sel) == j);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rr_q       <= '0;
            tgt_push_q <= '0;
            err_push_q <= 1'b0;
            err_free_q <= ERR_CW'(ERR_DEPTH);
            for (int k = 0; k < NT; k++) begin
                cnt_q[k] <= CNT_W'(CREDITS);
            end
        end else begin
            if (grant_v) begin
                rr_q <= (int'(sel) == NM - 1) ? '0 : sel + 1'b1;
            end
            for (int k = 0; k < NT; k++) begin
                tgt_push_q[k] <= grant_v && hit[sel] && (idx[sel] == fabric_pkg::IDX_W'(k));
                cnt_q[k]      <= cnt_q[k] + CNT_W'(tgt_credit_i[k]) - CNT_W'(tgt_push_q[k]);
            end
            err_push_q <= grant_v && !hit[sel];
            err_free_q <= err_free_q + ERR_CW'(err_pop) - ERR_CW'(err_push_q);
        end
    end

    // Accepted request with src stamped
    always_ff @(posedge clk_i) begin
        if (grant_v) begin
            req_q     <= mst_req_i[sel];
            req_q.src <= sel;
        end
    end

    assign tgt_push_o = tgt_push_q;

    for (genvar k = 0; k < NT; k++) begin : g_tgt_req
        assign tgt_req_o[k] = req_q;
    end

    // ----------------------------------------------------------------------
    // Decode-error responses
    // ----------------------------------------------------------------------
    assign err_rsp_d.rdata = '0;
    assign err_rsp_d.err   = 1'b1;
    assign err_rsp_d.tag   = req_q.tag;
    assign err_rsp_d.src   = req_q.src;
    assign err_pop         = err_rsp_valid_o && err_rsp_ready_i;

    credit_fifo #(
        .DEPTH     ( ERR_DEPTH         ),
        .payload_t ( fabric_pkg::rsp_t )
    ) i_err_fifo (
        .clk_i    ( clk_i      ),
        .rst_n_i  ( rst_n_i    ),
        .push_i   ( err_push_q ),
        .data_i   ( err_rsp_d  ),
        .pop_i    ( err_pop    ),
        .data_o   ( err_rsp_o  ),
        .empty_o  ( err_empty  ),
        .credit_o (            )
    );

    assign err_rsp_valid_o = !err_empty;

endmodule

`default_nettype wire

// ==== hw/credit_fifo.sv ====
// Sender must track free slots from credit_o; a push into a full queue without a pop is dropped
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
    parameter int unsigned DEPTH     = 4,
    parameter type         payload_t = logic [31:0]
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     empty_o,
    output logic     credit_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    payload_t         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign empty_o  = (count_q == '0);
    assign do_pop   = pop_i && !empty_o;
    assign do_push  = push_i && ((count_q != CNT_W'(DEPTH)) || do_pop);
    assign credit_o = do_pop;
    assign data_o   = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/fabric_pkg.sv ====
// Region k spans k<<28 upward; only the first TARGET_WORDS words of a region are backed by RAM
`default_nettype none

package fabric_pkg;

    localparam int unsigned ADDR_W       = 32;
    localparam int unsigned DATA_W       = 32;
    localparam int unsigned BE_W         = DATA_W / 8;
    localparam int unsigned NUM_MASTERS  = 2;
    localparam int unsigned NUM_TARGETS  = 3;
    localparam int unsigned TAG_W        = 4;
    localparam int unsigned SRC_W        = 1;
    localparam int unsigned REGION_SHIFT = 28;
    localparam int unsigned IDX_W        = ADDR_W - REGION_SHIFT;
    localparam int unsigned WORD_LSB     = $clog2(BE_W);

    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   be;
        logic [DATA_W-1:0] wdata;
        logic [TAG_W-1:0]  tag;
        logic [SRC_W-1:0]  src;
    } req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
        logic [TAG_W-1:0]  tag;
        logic [SRC_W-1:0]  src;
    } rsp_t;

    // ----------------------------------------------------------------------
    // Region map
    // ----------------------------------------------------------------------
    function automatic logic [IDX_W-1:0] region_idx(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1:REGION_SHIFT];
    endfunction

    // Word offset compare, so bits 1:0 never matter
    function automatic logic addr_hit(input logic [ADDR_W-1:0] addr, input int unsigned words);
        return (int'(region_idx(addr)) < NUM_TARGETS)
            && (addr[REGION_SHIFT-1:WORD_LSB] < words);
    endfunction

endpackage

`default_nettype wire
